// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f filelist.f --top-module tb_host_domain -o Vtb_host_domain

run: build
	./obj_dir/Vtb_host_domain | tee $(LOG)
	@! grep -q "Done: errors found" $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only -Wall -Isrc src/host_types_pkg.sv src/host_map_pkg.sv \
		src/edge_propagator_rx.sv src/llc_event_counters.sv src/cfg_regfile.sv \
		src/host_domain.sv --top-module host_domain

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+src
src/host_types_pkg.sv
src/host_map_pkg.sv
src/edge_propagator_rx.sv
src/llc_event_counters.sv
src/cfg_regfile.sv
src/host_domain.sv
test/host_domain_checker.sv
test/host_domain_props.sv
test/tb_host_domain.sv

// ==== src/cfg_regfile.sv ====
// ------------------------------
// AXI-Lite style config slave: LLC window, mailbox levels, counters
// One outstanding response per channel
// ------------------------------
`include "host_params.svh"

module cfg_regfile (
  input  logic                                          soc_clk_i,
  input  logic                                          reset_i,
  // Read channel
  input  logic                                          ar_valid_i,
  input  host_types_pkg::cfg_addr_t                     ar_addr_i,
  output logic                                          ar_ready_o,
  output logic                                          r_valid_o,
  output host_types_pkg::cfg_data_t                     r_data_o,
  input  logic                                          r_ready_i,
  // Write channel
  input  logic                                          w_valid_i,
  input  host_types_pkg::cfg_addr_t                     w_addr_i,
  input  host_types_pkg::cfg_data_t                     w_data_i,
  output logic                                          w_ready_o,
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  // Counter values
  input  host_types_pkg::count_t [`HOST_NUM_EVENTS-1:0] counts_i,
  // Config outputs
  output host_types_pkg::cfg_data_t                     llc_cache_addr_start_o,
  output host_types_pkg::cfg_data_t                     llc_cache_addr_end_o,
  output host_types_pkg::cfg_data_t                     llc_spm_addr_start_o,
  output logic                                          doorbell_irq_o,
  output logic                                          completion_irq_o
);

  logic                      r_valid_q;
  logic                      b_valid_q;
  logic                      rd_acc;
  logic                      wr_acc;
  host_types_pkg::cfg_data_t rd_data;
  host_types_pkg::cfg_data_t r_data_q;
  host_types_pkg::cfg_data_t cache_start_q;
  host_types_pkg::cfg_data_t cache_end_q;
  host_types_pkg::cfg_data_t spm_start_q;
  logic                      doorbell_q;
  logic                      completion_q;

  assign ar_ready_o = ~r_valid_q;
  assign w_ready_o  = ~b_valid_q;
  assign rd_acc     = ar_valid_i & ar_ready_o;
  assign wr_acc     = w_valid_i & w_ready_o;

  // Read response flag
  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_acc) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Write response flag
  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_acc) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  // Counters and unlisted offsets ignore writes
  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
      doorbell_q    <= 1'b0;
      completion_q  <= 1'b0;
    end else if (wr_acc) begin
      case (w_addr_i)
        host_map_pkg::CACHE_START_OFS: cache_start_q <= w_data_i;
        host_map_pkg::CACHE_END_OFS:   cache_end_q   <= w_data_i;
        host_map_pkg::SPM_START_OFS:   spm_start_q   <= w_data_i;
        host_map_pkg::DOORBELL_OFS:    doorbell_q    <= w_data_i[0];
        host_map_pkg::COMPLETION_OFS:  completion_q  <= w_data_i[0];
        default: ;
      endcase
    end
  end

  // Counts seen here are the pre-pulse values
  always_comb begin
    rd_data = host_map_pkg::UNMAPPED_DATA;
    case (ar_addr_i)
      host_map_pkg::CACHE_START_OFS: rd_data = cache_start_q;
      host_map_pkg::CACHE_END_OFS:   rd_data = cache_end_q;
      host_map_pkg::SPM_START_OFS:   rd_data = spm_start_q;
      host_map_pkg::DOORBELL_OFS:    rd_data = host_types_pkg::cfg_data_t'(doorbell_q);
      host_map_pkg::COMPLETION_OFS:  rd_data = host_types_pkg::cfg_data_t'(completion_q);
      host_map_pkg::RD_HIT_OFS:      rd_data = counts_i[0];
      host_map_pkg::RD_MISS_OFS:     rd_data = counts_i[1];
      host_map_pkg::WR_HIT_OFS:      rd_data = counts_i[2];
      host_map_pkg::WR_MISS_OFS:     rd_data = counts_i[3];
      host_map_pkg::DMA_EVT_OFS:     rd_data = counts_i[4];
      default: ;
    endcase
  end

  // Held while the response waits for r_ready_i
  always_ff @(posedge soc_clk_i) begin
    if (rd_acc) begin
      r_data_q <= rd_data;
    end
  end

  assign r_valid_o              = r_valid_q;
  assign r_data_o               = r_data_q;
  assign b_valid_o              = b_valid_q;
  assign llc_cache_addr_start_o = cache_start_q;
  assign llc_cache_addr_end_o   = cache_end_q;
  assign llc_spm_addr_start_o   = spm_start_q;
  assign doorbell_irq_o         = doorbell_q;
  assign completion_irq_o       = completion_q;

endmodule

// ==== src/edge_propagator_rx.sv ====
// ------------------------------
// Receiving side of a toggle-based event crossing
// One valid_o pulse per toggle of valid_i, ack_o back to the sender
// ------------------------------
`include "host_params.svh"

module edge_propagator_rx (
  input  logic soc_clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [`HOST_SYNC_STAGES-1:0] sync_q;
  logic                         level_q;
  logic                         valid_q;

  always_ff @(posedge soc_clk_i) begin
    if (reset_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[`HOST_SYNC_STAGES-2:0], valid_i};
      level_q <= sync_q[`HOST_SYNC_STAGES-1];
      // Any change of the synced level is one event
      valid_q <= sync_q[`HOST_SYNC_STAGES-1] ^ level_q;
    end
  end

  assign ack_o   = sync_q[`HOST_SYNC_STAGES-1];
  assign valid_o = valid_q;

endmodule

// ==== src/host_domain.sv ====
// ------------------------------
// Host domain top: config slave, LLC event counters, DMA event receiver
// ------------------------------
`include "host_params.svh"

module host_domain (
  input  logic                      soc_clk_i,
  input  logic                      reset_i,
  input  logic                      ar_valid_i,
  input  host_types_pkg::cfg_addr_t ar_addr_i,
  output logic                      ar_ready_o,
  output logic                      r_valid_o,
  output host_types_pkg::cfg_data_t r_data_o,
  input  logic                      r_ready_i,
  input  logic                      w_valid_i,
  input  host_types_pkg::cfg_addr_t w_addr_i,
  input  host_types_pkg::cfg_data_t w_data_i,
  output logic                      w_ready_o,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  input  logic                      llc_rd_hit_i,
  input  logic                      llc_rd_miss_i,
  input  logic                      llc_wr_hit_i,
  input  logic                      llc_wr_miss_i,
  input  logic                      dma_pe_evt_valid_i,
  output host_types_pkg::cfg_data_t llc_cache_addr_start_o,
  output host_types_pkg::cfg_data_t llc_cache_addr_end_o,
  output host_types_pkg::cfg_data_t llc_spm_addr_start_o,
  output logic                      doorbell_irq_o,
  output logic                      completion_irq_o,
  output logic                      dma_pe_evt_ack_o
);

  logic                                          dma_evt;
  host_types_pkg::event_vec_t                    events;
  host_types_pkg::count_t [`HOST_NUM_EVENTS-1:0] counts;

  // Cluster DMA event toggle
  edge_propagator_rx i_dma_evt_rx (
    .soc_clk_i ( soc_clk_i          ),
    .reset_i   ( reset_i            ),
    .valid_i   ( dma_pe_evt_valid_i ),
    .valid_o   ( dma_evt            ),
    .ack_o     ( dma_pe_evt_ack_o   )
  );

  assign events = {dma_evt, llc_wr_miss_i, llc_wr_hit_i, llc_rd_miss_i, llc_rd_hit_i};

  llc_event_counters i_counters (
    .soc_clk_i ( soc_clk_i ),
    .reset_i   ( reset_i   ),
    .events_i  ( events    ),
    .counts_o  ( counts    )
  );

  cfg_regfile i_cfg_regfile (
    .soc_clk_i, .reset_i,
    .ar_valid_i, .ar_addr_i, .ar_ready_o, .r_valid_o, .r_data_o, .r_ready_i,
    .w_valid_i, .w_addr_i, .w_data_i, .w_ready_o, .b_valid_o, .b_ready_i,
    .counts_i  ( counts ),
    .llc_cache_addr_start_o, .llc_cache_addr_end_o, .llc_spm_addr_start_o,
    .doorbell_irq_o, .completion_irq_o
  );

endmodule

// ==== src/host_map_pkg.sv ====
// ------------------------------
// Config register offsets and the value returned for unmapped reads
// ------------------------------
package host_map_pkg;

  // LLC address window registers
  localparam host_types_pkg::cfg_addr_t CACHE_START_OFS = 8'h00;
  localparam host_types_pkg::cfg_addr_t CACHE_END_OFS   = 8'h04;
  localparam host_types_pkg::cfg_addr_t SPM_START_OFS   = 8'h08;
  // Mailbox interrupt levels, bit 0 only
  localparam host_types_pkg::cfg_addr_t DOORBELL_OFS    = 8'h0C;
  localparam host_types_pkg::cfg_addr_t COMPLETION_OFS  = 8'h10;
  // Read-only event counters
  localparam host_types_pkg::cfg_addr_t RD_HIT_OFS      = 8'h14;
  localparam host_types_pkg::cfg_addr_t RD_MISS_OFS     = 8'h18;
  localparam host_types_pkg::cfg_addr_t WR_HIT_OFS      = 8'h1C;
  localparam host_types_pkg::cfg_addr_t WR_MISS_OFS     = 8'h20;
  localparam host_types_pkg::cfg_addr_t DMA_EVT_OFS     = 8'h24;

  localparam host_types_pkg::cfg_data_t UNMAPPED_DATA = 32'hDEADF000;

endpackage

// ==== src/host_params.svh ====
// ------------------------------
// Widths and counts shared by the host domain RTL and its testbench
// Include wherever a width or count is needed
// ------------------------------
`ifndef HOST_PARAMS_SVH
`define HOST_PARAMS_SVH

// Config bus
`define HOST_CFG_ADDR_W 8
`define HOST_CFG_DATA_W 32

// Event counters, four LLC events plus the DMA event
`define HOST_COUNT_W 32
`define HOST_NUM_EVENTS 5

`define HOST_SYNC_STAGES 2

`endif

// ==== src/host_types_pkg.sv ====
// ------------------------------
// Vector types for config addresses, data and event counts
// ------------------------------
`include "host_params.svh"

package host_types_pkg;

  typedef logic [`HOST_CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`HOST_CFG_DATA_W-1:0] cfg_data_t;
  typedef logic [`HOST_COUNT_W-1:0] count_t;

  // Bit order: rd hit, rd miss, wr hit, wr miss, DMA
  typedef logic [`HOST_NUM_EVENTS-1:0] event_vec_t;

endpackage

// ==== src/llc_event_counters.sv ====
// ------------------------------
// Wrapping counters, one per event pulse bit
// ------------------------------
`include "host_params.svh"

module llc_event_counters (
  input  logic                                              soc_clk_i,
  input  logic                                              reset_i,
  input  host_types_pkg::event_vec_t                        events_i,
  output host_types_pkg::count_t [`HOST_NUM_EVENTS-1:0]     counts_o
);

  host_types_pkg::count_t [`HOST_NUM_EVENTS-1:0] count_q;

  genvar i;
  generate
    for (i = 0; i < `HOST_NUM_EVENTS; i++) begin : g_cnt
      always_ff @(posedge soc_clk_i) begin
        if (reset_i) begin
          count_q[i] <= '0;
        end else if (events_i[i]) begin
          // Wraps at full scale
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  endgenerate

  assign counts_o = count_q;

endmodule

// ==== test/host_domain_checker.sv ====
// ------------------------------
// Compares read data and config outputs of host_domain with expected values
// Prints one line per test and the closing counts
// ------------------------------
module host_domain_checker (
  input  logic                      soc_clk_i,
  input  logic                      reset_i,
  input  logic                      ar_valid_i,
  input  logic                      ar_ready_i,
  input  logic                      r_valid_i,
  input  logic                      r_ready_i,
  input  host_types_pkg::cfg_data_t r_data_i,
  input  host_types_pkg::cfg_data_t exp_rdata_i,
  input  host_types_pkg::cfg_data_t start_i,
  input  host_types_pkg::cfg_data_t end_i,
  input  host_types_pkg::cfg_data_t spm_i,
  input  host_types_pkg::cfg_data_t exp_start_i,
  input  host_types_pkg::cfg_data_t exp_end_i,
  input  host_types_pkg::cfg_data_t exp_spm_i,
  input  logic                      db_i,
  input  logic                      cp_i,
  input  logic                      exp_db_i,
  input  logic                      exp_cp_i,
  input  logic                      step_done_i,
  input  int                        step_i,
  input  int                        tb_errs_i,
  input  logic                      finish_i,
  output int                        errors_o
);

  int errors_q     = 0;
  int step_errs    = 0;
  int tests        = 0;
  int wait_cnt     = 0;
  int tb_errs_seen = 0;
  bit rd_pending   = 0;

  task automatic compare(input string name, input host_types_pkg::cfg_data_t exp,
                         input host_types_pkg::cfg_data_t act);
    if (exp !== act) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      step_errs++;
      errors_q++;
    end
  endtask

  always @(posedge soc_clk_i) begin
    if (!reset_i) begin
      if (ar_valid_i && ar_ready_i) begin
        rd_pending = 1;
        wait_cnt   = 0;
      end else if (rd_pending) begin
        wait_cnt++;
      end
      if (r_valid_i && r_ready_i) begin
        compare("r_data_o", exp_rdata_i, r_data_i);
        rd_pending = 0;
      end
      // Must fire before the stimulus gives up and issues the next read
      if (rd_pending && wait_cnt > 16) begin
        $display("test %0d: read was accepted but no response came within 16 cycles", step_i);
        step_errs++;
        errors_q++;
        rd_pending = 0;
      end
      if (step_done_i) begin
        compare("llc_cache_addr_start_o", exp_start_i, start_i);
        compare("llc_cache_addr_end_o", exp_end_i, end_i);
        compare("llc_spm_addr_start_o", exp_spm_i, spm_i);
        compare("doorbell_irq_o", 32'(exp_db_i), 32'(db_i));
        compare("completion_irq_o", 32'(exp_cp_i), 32'(cp_i));
        // Handshake timeouts seen by the stimulus side during this test
        if (tb_errs_i != tb_errs_seen) begin
          step_errs += tb_errs_i - tb_errs_seen;
          errors_q += tb_errs_i - tb_errs_seen;
          tb_errs_seen = tb_errs_i;
        end
        if (step_errs == 0)
          $display("test %0d: pass", step_i);
        else
          $display("test %0d: FAIL with %0d errors", step_i, step_errs);
        step_errs = 0;
        tests++;
      end
      if (finish_i)
        $display("tests run: %0d, errors: %0d", tests, errors_q);
    end
  end

  assign errors_o = errors_q;

endmodule

// ==== test/host_domain_props.sv ====
// ------------------------------
// Concurrent checks on the config channel flags, reset values and DMA ack
// Attached to host_domain with bind
// ------------------------------
module host_domain_props (
  input logic                      soc_clk_i,
  input logic                      reset_i,
  input logic                      ar_ready_o,
  input logic                      w_ready_o,
  input logic                      r_valid_o,
  input logic                      r_ready_i,
  input host_types_pkg::cfg_data_t r_data_o,
  input logic                      b_valid_o,
  input logic                      b_ready_i,
  input host_types_pkg::cfg_data_t llc_cache_addr_start_o,
  input logic                      doorbell_irq_o,
  input logic                      completion_irq_o,
  input logic                      dma_pe_evt_valid_i,
  input logic                      dma_pe_evt_ack_o
);

  a_r_hold: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> r_valid_o)
    else $error("r_valid_o dropped before r_ready_i");

  a_r_data_stable: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> $stable(r_data_o))
    else $error("r_data_o changed while stalled");

  a_b_hold: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    b_valid_o && !b_ready_i |=> b_valid_o)
    else $error("b_valid_o dropped before b_ready_i");

  a_reset_values: assert property (@(posedge soc_clk_i)
    reset_i |=> !r_valid_o && !b_valid_o && ar_ready_o && w_ready_o && !doorbell_irq_o
      && !completion_irq_o && !dma_pe_evt_ack_o && llc_cache_addr_start_o == '0)
    else $error("outputs not at reset values");

  // Ack is the input seen through the two synchronizer stages
  a_ack_delay: assert property (@(posedge soc_clk_i) disable iff (reset_i)
    !$past(reset_i, 1) && !$past(reset_i, 2) |-> dma_pe_evt_ack_o == $past(dma_pe_evt_valid_i, 2))
    else $error("dma_pe_evt_ack_o is not the input delayed by 2 cycles");

endmodule

// ==== test/tb_host_domain.sv ====
// ------------------------------
// Table-driven register, event and DMA tests for host_domain
// Inputs change on the falling clock edge
// ------------------------------
module tb_host_domain;

  localparam int K_WR = 0, K_RD = 1, K_BURST = 2, K_DMA = 3, K_WRRD = 4;

  logic soc_clk = 0, reset = 1;
  logic ar_valid = 0, r_ready = 0, w_valid = 0, b_ready = 0, dma_valid = 0;
  logic [7:0] ar_addr = '0, w_addr = '0;
  logic [31:0] w_data = '0;
  logic [3:0] llc_pulse = '0;
  logic ar_ready, r_valid, w_ready, b_valid, db_irq, cp_irq, dma_ack;
  host_types_pkg::cfg_data_t r_data, start_o, end_o, spm_o;
  // Expected outputs kept from the register map rules
  host_types_pkg::cfg_data_t exp_rdata = '0, m_start = '0, m_end = '0, m_spm = '0;
  logic m_db = 0, m_cp = 0, step_done = 0, finish = 0;
  int step_idx = 0, tb_errs = 0, chk_errs;
  logic [7:0] lfsr_q = 8'd81;
  int kind_q[$], ofs_q[$], data_q[$], exp_q[$];

  host_domain dut (
    .soc_clk_i(soc_clk), .reset_i(reset),
    .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_data_o(r_data), .r_ready_i(r_ready),
    .w_valid_i(w_valid), .w_addr_i(w_addr), .w_data_i(w_data), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .llc_rd_hit_i(llc_pulse[0]), .llc_rd_miss_i(llc_pulse[1]),
    .llc_wr_hit_i(llc_pulse[2]), .llc_wr_miss_i(llc_pulse[3]),
    .dma_pe_evt_valid_i(dma_valid),
    .llc_cache_addr_start_o(start_o), .llc_cache_addr_end_o(end_o),
    .llc_spm_addr_start_o(spm_o), .doorbell_irq_o(db_irq), .completion_irq_o(cp_irq),
    .dma_pe_evt_ack_o(dma_ack)
  );

  host_domain_checker chk (
    .soc_clk_i(soc_clk), .reset_i(reset), .ar_valid_i(ar_valid), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_ready_i(r_ready), .r_data_i(r_data), .exp_rdata_i(exp_rdata),
    .start_i(start_o), .end_i(end_o), .spm_i(spm_o),
    .exp_start_i(m_start), .exp_end_i(m_end), .exp_spm_i(m_spm),
    .db_i(db_irq), .cp_i(cp_irq), .exp_db_i(m_db), .exp_cp_i(m_cp),
    .step_done_i(step_done), .step_i(step_idx), .tb_errs_i(tb_errs),
    .finish_i(finish), .errors_o(chk_errs)
  );

  bind host_domain host_domain_props props (
    .soc_clk_i, .reset_i, .ar_ready_o, .w_ready_o, .r_valid_o, .r_ready_i, .r_data_o,
    .b_valid_o, .b_ready_i, .llc_cache_addr_start_o, .doorbell_irq_o, .completion_irq_o,
    .dma_pe_evt_valid_i, .dma_pe_evt_ack_o
  );

  initial begin
    forever #4 soc_clk = ~soc_clk;
  end

  // Taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic add_step(input int kind, input int ofs, input int data, input int exp);
    kind_q.push_back(kind);
    ofs_q.push_back(ofs);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  task automatic model_write(input logic [7:0] ofs, input logic [31:0] data);
    case (ofs)
      8'h00: m_start = data;
      8'h04: m_end = data;
      8'h08: m_spm = data;
      8'h0C: m_db = data[0];
      8'h10: m_cp = data[0];
      default: ;
    endcase
  endtask

  // Waits for r or b valid, stalls 0 to 3 cycles, then completes the handshake
  task automatic take_response(input bit is_wr);
    logic [1:0] stall;
    int wait_cnt;
    lfsr_q = lfsr_next(lfsr_q);
    stall[0] = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    stall[1] = lfsr_q[0];
    wait_cnt = 0;
    while (!(is_wr ? b_valid : r_valid) && wait_cnt < 20) begin
      @(negedge soc_clk);
      wait_cnt++;
    end
    if (wait_cnt >= 20) begin
      if (is_wr) begin
        $display("test %0d: write was accepted but b_valid_o never rose", step_idx);
        tb_errs++;
      end
      return;
    end
    repeat (stall) @(negedge soc_clk);
    if (is_wr) b_ready = 1;
    else r_ready = 1;
    @(negedge soc_clk);
    b_ready = 0;
    r_ready = 0;
  endtask

  task automatic run_access(input bit rd, input bit wr, input logic [7:0] ofs,
                            input logic [31:0] data);
    bit rd_acc;
    bit wr_acc;
    int wait_cnt;
    @(negedge soc_clk);
    ar_valid = rd;
    ar_addr  = ofs;
    w_valid  = wr;
    w_addr   = ofs;
    w_data   = data;
    rd_acc   = !rd;
    wr_acc   = !wr;
    wait_cnt = 0;
    while (!(rd_acc && wr_acc) && wait_cnt < 20) begin
      // Ready is stable here and decides the next rising edge
      if (ar_valid && ar_ready) rd_acc = 1;
      if (w_valid && w_ready) wr_acc = 1;
      @(negedge soc_clk);
      if (rd_acc) ar_valid = 0;
      if (wr_acc) w_valid = 0;
      wait_cnt++;
    end
    if (!(rd_acc && wr_acc)) begin
      $display("test %0d: request was never accepted", step_idx);
      tb_errs++;
      ar_valid = 0;
      w_valid = 0;
      return;
    end
    if (wr) model_write(ofs, data);
    if (rd) take_response(0);
    if (wr) take_response(1);
  endtask

  task automatic llc_burst(input int idx, input int n);
    repeat (n) begin
      @(negedge soc_clk);
      llc_pulse[idx] = 1;
      @(negedge soc_clk);
      llc_pulse[idx] = 0;
    end
    @(negedge soc_clk);
  endtask

  task automatic dma_toggles(input int k);
    int wait_cnt;
    repeat (k) begin
      @(negedge soc_clk);
      dma_valid = ~dma_valid;
      wait_cnt = 0;
      while (dma_ack !== dma_valid && wait_cnt < 20) begin
        @(negedge soc_clk);
        wait_cnt++;
      end
      if (wait_cnt >= 20) begin
        $display("test %0d: dma_pe_evt_ack_o never followed the toggle", step_idx);
        tb_errs++;
      end
    end
    // Pulse and count land after the ack
    repeat (3) @(negedge soc_clk);
  endtask

  initial begin
    // Reset values and unmapped offsets
    add_step(K_RD, 'h00, 0, 0);
    add_step(K_RD, 'h04, 0, 0);
    add_step(K_RD, 'h08, 0, 0);
    add_step(K_RD, 'h0C, 0, 0);
    add_step(K_RD, 'h10, 0, 0);
    add_step(K_RD, 'h14, 0, 0);
    add_step(K_RD, 'h18, 0, 0);
    add_step(K_RD, 'h1C, 0, 0);
    add_step(K_RD, 'h20, 0, 0);
    add_step(K_RD, 'h24, 0, 0);
    add_step(K_RD, 'h28, 0, 'hDEADF000);
    add_step(K_RD, 'hFC, 0, 'hDEADF000);
    add_step(K_WR, 'h00, 'h80000000, 0);
    add_step(K_WR, 'h04, 'h8FFFFFFF, 0);
    add_step(K_WR, 'h08, 'h10000000, 0);
    add_step(K_RD, 'h00, 0, 'h80000000);
    add_step(K_RD, 'h04, 0, 'h8FFFFFFF);
    add_step(K_RD, 'h08, 0, 'h10000000);
    // Counter writes are ignored
    add_step(K_WR, 'h14, 'h1234, 0);
    add_step(K_WR, 'h24, 'h55, 0);
    add_step(K_RD, 'h14, 0, 0);
    add_step(K_RD, 'h24, 0, 0);
    // Mailbox levels
    add_step(K_WR, 'h0C, 1, 0);
    add_step(K_RD, 'h0C, 0, 1);
    add_step(K_WR, 'h10, 3, 0);
    add_step(K_RD, 'h10, 0, 1);
    add_step(K_WR, 'h0C, 0, 0);
    add_step(K_RD, 'h0C, 0, 0);
    add_step(K_RD, 'h10, 0, 1);
    add_step(K_BURST, 'h14, 5, 0);
    add_step(K_BURST, 'h18, 3, 0);
    add_step(K_BURST, 'h1C, 7, 0);
    add_step(K_BURST, 'h20, 2, 0);
    add_step(K_RD, 'h14, 0, 5);
    add_step(K_RD, 'h18, 0, 3);
    add_step(K_RD, 'h1C, 0, 7);
    add_step(K_RD, 'h20, 0, 2);
    add_step(K_DMA, 'h24, 4, 0);
    add_step(K_RD, 'h24, 0, 4);
    // Read in the write's cycle still sees the old value
    add_step(K_WRRD, 'h00, 'h00004000, 'h80000000);
    add_step(K_RD, 'h00, 0, 'h00004000);

    repeat (10) @(posedge soc_clk);
    @(negedge soc_clk);
    reset = 0;

    for (int i = 0; i < kind_q.size(); i++) begin
      step_idx  = i;
      exp_rdata = exp_q[i];
      case (kind_q[i])
        K_WR:    run_access(0, 1, ofs_q[i], data_q[i]);
        K_RD:    run_access(1, 0, ofs_q[i], data_q[i]);
        K_WRRD:  run_access(1, 1, ofs_q[i], data_q[i]);
        K_BURST: llc_burst((ofs_q[i] - 'h14) / 4, data_q[i]);
        default: dma_toggles(data_q[i]);
      endcase
      @(negedge soc_clk);
      step_done = 1;
      @(negedge soc_clk);
      step_done = 0;
    end

    finish = 1;
    @(negedge soc_clk);
    finish = 0;
    @(negedge soc_clk);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    repeat (kind_q.size() * 40 + 10) @(posedge soc_clk);
    $display("Watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

endmodule
